//--- tb.f
src/freeListPkg.sv
src/bitFind.sv
src/slotPicker.sv
src/freeListMap.sv
src/freeListApb.sv
src/freeListTop.sv
bench/freeListBind_sva.sv
bench/freeListTb.sv

//--- run.sh
#!/bin/sh
# Build the free-list testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module freeListTb -f tb.f -o freeListSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/freeListSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q 'All tests passed!' sim.log; then
  exit 0
fi
exit 1

//--- bench/freeListTb.sv
module freeListTb;
  timeunit 1ns;
  timeprecision 1ps;

  import freeListPkg::*;

  logic clk;
  logic rstN;
  allocReqT allocReq;
  allocRespT allocResp;
  releaseReqT releaseReq;
  apbReqT apbReq;
  apbRespT apbResp;

  // Reference state, advanced once per driven cycle.
  logic [31:0] refBits;
  logic refEnable;
  logic refDouble;
  dataT refStallCount;
  logic [31:0] lcgState;
  int errorCount;
  int timeoutCount;

  freeListTop #(.NUM_TAGS(32)) dut_i (
    .clk(clk),
    .rstN(rstN),
    .allocReq(allocReq),
    .allocResp(allocResp),
    .releaseReq(releaseReq),
    .apbReq(apbReq),
    .apbResp(apbResp)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic checkTag(input string name, input tagT expVal, input tagT actVal);
    if (actVal !== expVal)
    begin
      $display("Error: %s expected 0x%0h, actual 0x%0h", name, expVal, actVal);
      errorCount++;
    end
  endtask

  task automatic checkData(input string name, input dataT expVal, input dataT actVal);
    if (actVal !== expVal)
    begin
      $display("Error: %s expected 0x%0h, actual 0x%0h", name, expVal, actVal);
      errorCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal)
    begin
      $display("Error: %s expected 0x%0h, actual 0x%0h", name, expVal, actVal);
      errorCount++;
    end
  endtask

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int countFree(input logic [31:0] bits);
    int cnt;
    cnt = 0;
    for (int k = 0; k < 32; k++)
      cnt += int'(bits[k]);
    return cnt;
  endfunction

  // Index of the (skip+1)th set bit from the bottom or the top, -1 if none.
  function automatic int findFree(input logic [31:0] bits, input bit fromTop, input int skip);
    int hits;
    int idx;
    logic [31:0] shifted;
    hits = 0;
    for (int k = 0; k < 32; k++)
    begin
      idx = fromTop ? 31 - k : k;
      shifted = bits >> idx;
      if (shifted[0])
      begin
        if (hits == skip)
          return idx;
        hits++;
      end
    end
    return -1;
  endfunction

  function automatic allocRespT expectResp(input logic valid, input logic [3:0] needed);
    allocRespT r;
    int idx;
    r = '0;
    r.stall = countFree(refBits) < 4;
    for (int s = 0; s < 4; s++)
    begin
      idx = findFree(refBits, s >= 2, s % 2); // Slots 2 and 3 count from the top.
      r.tag[s] = (idx < 0) ? '0 : tagT'(idx);
      r.grantValid[s] = valid & refEnable & ~r.stall & needed[s];
    end
    return r;
  endfunction

  // One allocation cycle; outputs are sampled before the next rising edge.
  task automatic stepAlloc(input logic valid, input logic [3:0] needed,
                           input logic [1:0] relValid, input tagT rel0, input tagT rel1);
    allocRespT expResp;
    logic [31:0] grantMask;
    logic [31:0] relMask;
    @(negedge clk);
    allocReq.valid = valid;
    allocReq.needed = needed;
    releaseReq.valid = relValid;
    releaseReq.tag[0] = rel0;
    releaseReq.tag[1] = rel1;
    apbReq = '0;
    #2;
    expResp = expectResp(valid, needed);
    checkBit("allocResp.stall", expResp.stall, allocResp.stall);
    grantMask = '0;
    for (int s = 0; s < 4; s++)
    begin
      checkBit($sformatf("allocResp.grantValid[%0d]", s), expResp.grantValid[s],
               allocResp.grantValid[s]);
      if (!expResp.stall)
        checkTag($sformatf("allocResp.tag[%0d]", s), expResp.tag[s], allocResp.tag[s]);
      if (expResp.grantValid[s])
        grantMask |= 32'd1 << expResp.tag[s];
    end
    relMask = '0;
    if (relValid[0])
      relMask |= 32'd1 << rel0;
    if (relValid[1])
      relMask |= 32'd1 << rel1;
    if ((relMask & refBits) != '0 || (relValid == 2'b11 && rel0 == rel1))
      refDouble = 1'b1; // Already free, or one tag on both ports.
    if (valid && refEnable && expResp.stall)
      refStallCount++;
    refBits = (refBits & ~grantMask) | relMask;
  endtask

  task automatic apbAccess(input logic write, input regAddrT addr, input dataT wdata,
                           output dataT rdata);
    int waitCycles;
    @(negedge clk);
    allocReq = '0;
    releaseReq = '0;
    apbReq.psel = 1'b1; // Setup phase.
    apbReq.penable = 1'b0;
    apbReq.pwrite = write;
    apbReq.paddr = addr;
    apbReq.pwdata = wdata;
    @(negedge clk);
    apbReq.penable = 1'b1;
    #2;
    waitCycles = 0;
    while (!apbResp.pready && waitCycles < 16)
    begin
      @(negedge clk);
      #2;
      waitCycles++;
    end
    if (!apbResp.pready)
    begin
      $display("Timeout: APB transfer to address 0x%0h never completed", addr);
      timeoutCount++;
    end
    rdata = apbResp.prdata;
    checkBit("apbResp.pslverr", 1'b0, apbResp.pslverr);
    @(negedge clk);
    apbReq = '0;
    if (write && addr == ctrlAddr)
      refEnable = wdata[0];
    if (write && addr == statusAddr && wdata[0])
      refDouble = 1'b0;
  endtask

  task automatic apbWrite(input regAddrT addr, input dataT wdata);
    dataT unused;
    apbAccess(1'b1, addr, wdata, unused);
  endtask

  task automatic apbRead(input regAddrT addr, output dataT rdata);
    apbAccess(1'b0, addr, '0, rdata);
  endtask

  task automatic testReset();
    dataT rd;
    apbRead(freeCountAddr, rd);
    checkData("freeCount", 32'd32, rd);
    apbRead(ctrlAddr, rd);
    checkData("ctrl", 32'd0, rd);
    apbRead(stallCountAddr, rd);
    checkData("stallCount", 32'd0, rd);
    apbRead(statusAddr, rd);
    checkData("status", 32'd0, rd);
    stepAlloc(1'b1, 4'hF, 2'b00, '0, '0); // Disabled, so nothing granted.
  endtask

  task automatic testSlots();
    dataT rd;
    apbWrite(ctrlAddr, 32'd1);
    apbRead(ctrlAddr, rd);
    checkData("ctrl", 32'd1, rd);
    stepAlloc(1'b1, 4'h0, 2'b00, '0, '0);
    checkTag("allocResp.tag[0]", 8'd0, allocResp.tag[0]);
    checkTag("allocResp.tag[1]", 8'd1, allocResp.tag[1]);
    checkTag("allocResp.tag[2]", 8'd31, allocResp.tag[2]);
    checkTag("allocResp.tag[3]", 8'd30, allocResp.tag[3]);
    repeat (6)
      stepAlloc(1'b1, 4'(nextRand() >> 7), 2'b00, '0, '0);
    apbRead(freeCountAddr, rd);
    checkData("freeCount", dataT'(countFree(refBits)), rd);
  endtask

  task automatic testStall();
    int freeNow;
    int guard;
    dataT base;
    dataT rd;
    apbRead(stallCountAddr, base);
    freeNow = countFree(refBits);
    guard = 0;
    // Take just enough to land on three free tags.
    while (freeNow > 3 && guard < 40)
    begin
      stepAlloc(1'b1, (freeNow >= 7) ? 4'hF : 4'((1 << (freeNow - 3)) - 1), 2'b00, '0, '0);
      freeNow = countFree(refBits);
      guard++;
    end
    if (freeNow > 3)
    begin
      $display("Timeout: free list never drained to three tags");
      timeoutCount++;
    end
    repeat (5)
      stepAlloc(1'b1, 4'hF, 2'b00, '0, '0);
    checkBit("allocResp.stall", 1'b1, allocResp.stall);
    apbRead(stallCountAddr, rd);
    checkData("stallCount", refStallCount, rd);
    checkData("stallCount delta", 32'd5, rd - base);
  endtask

  task automatic testRelease();
    tagT relA;
    tagT relB;
    int nAlloc;
    int k0;
    int k1;
    dataT rd;
    relA = tagT'(findFree(~refBits, 1'b0, 0));
    relB = tagT'(findFree(~refBits, 1'b0, 1));
    stepAlloc(1'b1, 4'hF, 2'b11, relA, relB); // Still stalled in this cycle.
    stepAlloc(1'b1, 4'h0, 2'b00, '0, '0);
    checkTag("allocResp.tag[0]", relA, allocResp.tag[0]);
    checkTag("allocResp.tag[1]", relB, allocResp.tag[1]);
    repeat (8)
    begin
      nAlloc = 32 - countFree(refBits);
      k0 = int'(nextRand() >> 8) % nAlloc;
      k1 = (k0 + 1 + int'(nextRand() >> 8) % (nAlloc - 1)) % nAlloc;
      stepAlloc(1'b1, 4'(nextRand() >> 7), 2'b11, tagT'(findFree(~refBits, 1'b0, k0)),
                tagT'(findFree(~refBits, 1'b0, k1)));
    end
    apbRead(freeCountAddr, rd);
    checkData("freeCount", dataT'(countFree(refBits)), rd);
  endtask

  task automatic testDoubleFree();
    tagT tagA;
    dataT rd;
    apbRead(statusAddr, rd);
    checkData("status", dataT'(refDouble), rd);
    stepAlloc(1'b0, 4'h0, 2'b01, tagT'(findFree(refBits, 1'b0, 0)), '0);
    apbRead(statusAddr, rd);
    checkData("status", dataT'(refDouble), rd);
    apbWrite(statusAddr, 32'd1);
    apbRead(statusAddr, rd);
    checkData("status", dataT'(refDouble), rd);
    // Same allocated tag on both ports.
    tagA = tagT'(findFree(~refBits, 1'b0, 0));
    stepAlloc(1'b0, 4'h0, 2'b11, tagA, tagA);
    apbRead(statusAddr, rd);
    checkData("status", dataT'(refDouble), rd);
    apbWrite(statusAddr, 32'd1);
    apbRead(statusAddr, rd);
    checkData("status", dataT'(refDouble), rd);
    apbRead(freeCountAddr, rd);
    checkData("freeCount", dataT'(countFree(refBits)), rd);
  endtask

  initial
  begin
    rstN = 1'b0;
    allocReq = '0;
    releaseReq = '0;
    apbReq = '0;
    refBits = '1;
    refEnable = 1'b0;
    refDouble = 1'b0;
    refStallCount = '0;
    lcgState = 32'h9ff5_144d;
    errorCount = 0;
    timeoutCount = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    testReset();
    testSlots();
    testStall();
    testRelease();
    testDoubleFree();
    $display("Finished with %0d errors and %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Guard against a stuck run.
  initial
  begin
    #200_000;
    $display("Simulation ran past its time limit");
    $display("Test failures found");
    $finish;
  end

endmodule

//--- bench/freeListBind_sva.sv
module freeListChecks (
  input logic clk,
  input logic rstN,
  input freeListPkg::apbReqT apbReq,
  input freeListPkg::allocRespT allocResp,
  input freeListPkg::dataT freeCount,
  input logic enable
);
  timeunit 1ns;
  timeprecision 1ps;

  import freeListPkg::*;

  logic ctrlWrite;
  logic enableSeen; // Set by the first write of 1 to ctrl.

  assign ctrlWrite = apbReq.psel & apbReq.penable & apbReq.pwrite &
                     (apbReq.paddr == ctrlAddr);

  always_ff @(posedge clk)
  begin
    if (!rstN)
      enableSeen <= 1'b0;
    else if (ctrlWrite && apbReq.pwdata[0])
      enableSeen <= 1'b1;
  end

  // Fewer than four free tags must stall and hand out nothing.
  noGrantOnStall: assert property (@(posedge clk) disable iff (!rstN)
    freeCount < 32'd4 |-> allocResp.stall && allocResp.grantValid == 4'b0000)
    else $error("grant issued with fewer than four free tags");

  ctrlWriteLands: assert property (@(posedge clk) disable iff (!rstN)
    ctrlWrite |=> enable == $past(apbReq.pwdata[0]))
    else $error("ctrl write did not reach enable");

  // Enable comes up clear after reset.
  noGrantBeforeEnable: assert property (@(posedge clk) disable iff (!rstN)
    !enableSeen |-> allocResp.grantValid == 4'b0000)
    else $error("grant issued before enable was set");

endmodule

bind freeListTop freeListChecks checks_i (
  .clk(clk),
  .rstN(rstN),
  .apbReq(apbReq),
  .allocResp(allocResp),
  .freeCount(freeCount),
  .enable(enable)
);

//--- src/freeListTop.sv
module freeListTop #(
  parameter int NUM_TAGS = 32
) (
  input logic clk,
  input logic rstN,
  input freeListPkg::allocReqT allocReq,
  output freeListPkg::allocRespT allocResp,
  input freeListPkg::releaseReqT releaseReq,
  input freeListPkg::apbReqT apbReq,
  output freeListPkg::apbRespT apbResp
);

  import freeListPkg::*;

  logic [NUM_TAGS-1:0] freeBits;
  logic enable;
  dataT freeCount;
  logic doubleFree;
  logic doubleFreeClr;

  // Combinational tag selection from the current bitmap.
  slotPicker #(.NUM_TAGS(NUM_TAGS)) picker_i (
    .freeBits(freeBits),
    .allocReq(allocReq),
    .enable(enable),
    .allocResp(allocResp)
  );

  freeListMap #(.NUM_TAGS(NUM_TAGS)) map_i (
    .clk(clk),
    .rstN(rstN),
    .allocResp(allocResp),
    .releaseReq(releaseReq),
    .doubleFreeClr(doubleFreeClr),
    .freeBits(freeBits),
    .freeCount(freeCount),
    .doubleFree(doubleFree)
  );

  // Software view.
  freeListApb regs_i (
    .clk(clk),
    .rstN(rstN),
    .apbReq(apbReq),
    .apbResp(apbResp),
    .allocReq(allocReq),
    .stall(allocResp.stall),
    .freeCount(freeCount),
    .doubleFree(doubleFree),
    .enable(enable),
    .doubleFreeClr(doubleFreeClr)
  );

endmodule

//--- src/freeListApb.sv
module freeListApb (
  input logic clk,
  input logic rstN,
  input freeListPkg::apbReqT apbReq,
  output freeListPkg::apbRespT apbResp,
  input freeListPkg::allocReqT allocReq,
  input logic stall,
  input freeListPkg::dataT freeCount,
  input logic doubleFree,
  output logic enable,
  output logic doubleFreeClr
);

  import freeListPkg::*;

  logic access;
  logic wrAccess;
  logic ctrlSel;
  logic statusSel;
  dataT readData;
  dataT stallCount;

  assign access = apbReq.psel & apbReq.penable; // Access phase, no waits.
  assign wrAccess = access & apbReq.pwrite;

  // Decoded on the word index, so every 4-bit address hits a register.
  always_comb
  begin
    ctrlSel = 1'b0;
    statusSel = 1'b0;
    readData = '0;
    case (apbReq.paddr[3:2])
      ctrlAddr[3:2]:
      begin
        ctrlSel = 1'b1;
        readData = dataT'(enable);
      end
      freeCountAddr[3:2]: readData = freeCount;
      stallCountAddr[3:2]: readData = stallCount;
      statusAddr[3:2]:
      begin
        statusSel = 1'b1;
        readData = dataT'(doubleFree);
      end
    endcase
  end

  always_comb
  begin
    apbResp.prdata = (access && !apbReq.pwrite) ? readData : '0;
    apbResp.pready = 1'b1;
    apbResp.pslverr = 1'b0; // No address can miss.
  end

  // Clear lands at the edge that ends the access phase.
  assign doubleFreeClr = wrAccess & statusSel & apbReq.pwdata[0];

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      enable <= 1'b0;
      stallCount <= '0;
    end
    else
    begin
      if (wrAccess && ctrlSel)
        enable <= apbReq.pwdata[0];
      if (allocReq.valid && enable && stall)
        stallCount <= stallCount + dataT'(1); // Wraps.
    end
  end

endmodule

//--- src/freeListMap.sv
module freeListMap #(
  parameter int NUM_TAGS = 32
) (
  input logic clk,
  input logic rstN,
  input freeListPkg::allocRespT allocResp,
  input freeListPkg::releaseReqT releaseReq,
  input logic doubleFreeClr,
  output logic [NUM_TAGS-1:0] freeBits,
  output freeListPkg::dataT freeCount,
  output logic doubleFree
);

  import freeListPkg::*;

  logic [NUM_TAGS-1:0] grantMask;
  logic [NUM_TAGS-1:0] releaseMask;
  logic [NUM_TAGS-1:0] nextBits;
  logic doubleNow;

  function automatic dataT popCount(input logic [NUM_TAGS-1:0] vec);
    dataT cnt;
    cnt = '0;
    for (int i = 0; i < NUM_TAGS; i++)
      cnt += dataT'(vec[i]);
    return cnt;
  endfunction

  // Decode granted and released tags into bitmap masks.
  always_comb
  begin
    grantMask = '0;
    releaseMask = '0;
    for (int j = 0; j < NUM_TAGS; j++)
    begin
      for (int s = 0; s < 4; s++)
      begin
        if (allocResp.grantValid[s] && allocResp.tag[s] == tagT'(j))
          grantMask[j] = 1'b1;
      end
      for (int p = 0; p < 2; p++)
      begin
        if (releaseReq.valid[p] && releaseReq.tag[p] == tagT'(j))
          releaseMask[j] = 1'b1;
      end
    end
  end

  // Releases land after grants, so a returned tag is offered next cycle.
  assign nextBits = (freeBits & ~grantMask) | releaseMask;

  // Freeing an already free tag, or both ports on one tag.
  assign doubleNow = (|(releaseMask & freeBits)) |
                     (&releaseReq.valid & (releaseReq.tag[0] == releaseReq.tag[1]));

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      freeBits <= '1; // Everything free.
      freeCount <= dataT'(NUM_TAGS);
      doubleFree <= 1'b0;
    end
    else
    begin
      freeBits <= nextBits;
      freeCount <= popCount(nextBits);
      // A new double free beats a clear in the same cycle.
      doubleFree <= (doubleFree & ~doubleFreeClr) | doubleNow;
    end
  end

endmodule

//--- src/slotPicker.sv
module slotPicker #(
  parameter int NUM_TAGS = 32
) (
  input logic [NUM_TAGS-1:0] freeBits,
  input freeListPkg::allocReqT allocReq,
  input logic enable,
  output freeListPkg::allocRespT allocResp
);

  import freeListPkg::*;

  // One-hot finds, in slot order.
  logic [3:0][NUM_TAGS-1:0] hot;
  logic found1;
  logic found3;
  logic stall;

  function automatic tagT encodeHot(input logic [NUM_TAGS-1:0] oneHot);
    tagT idx;
    idx = '0;
    for (int i = 0; i < NUM_TAGS; i++)
    begin
      if (oneHot[i])
        idx |= tagT'(i);
    end
    return idx;
  endfunction

  bitFind #(.NUM_TAGS(NUM_TAGS), .FROM_TOP(1'b0)) lowFirst_i (
    .bits(freeBits),
    .oneHot(hot[0]),
    .found()
  );

  bitFind #(.NUM_TAGS(NUM_TAGS), .FROM_TOP(1'b0)) lowSecond_i (
    .bits(freeBits & ~hot[0]), // Lowest one masked off.
    .oneHot(hot[1]),
    .found(found1)
  );

  bitFind #(.NUM_TAGS(NUM_TAGS), .FROM_TOP(1'b1)) highFirst_i (
    .bits(freeBits),
    .oneHot(hot[2]),
    .found()
  );

  bitFind #(.NUM_TAGS(NUM_TAGS), .FROM_TOP(1'b1)) highSecond_i (
    .bits(freeBits & ~hot[2]),
    .oneHot(hot[3]),
    .found(found3)
  );

  // With fewer than four free tags the upper and lower picks overlap.
  assign stall = ~found1 | ~found3 | (hot[1] == hot[2]) | (hot[1] == hot[3]);

  always_comb
  begin
    allocResp.stall = stall;
    for (int s = 0; s < 4; s++)
    begin
      allocResp.tag[s] = encodeHot(hot[s]);
      allocResp.grantValid[s] = allocReq.valid & enable & ~stall & allocReq.needed[s];
    end
  end

endmodule

//--- src/bitFind.sv
module bitFind #(
  parameter int NUM_TAGS = 32,
  parameter bit FROM_TOP = 1'b0
) (
  input logic [NUM_TAGS-1:0] bits,
  output logic [NUM_TAGS-1:0] oneHot,
  output logic found
);

  // seen[i] is set once any bit earlier in the scan order was set.
  logic [NUM_TAGS:0] seen;

  assign seen[0] = 1'b0;

  for (genvar i = 0; i < NUM_TAGS; i++)
  begin : gScan
    // Scan order runs upward, or downward from the MSB.
    localparam int Pos = FROM_TOP ? NUM_TAGS - 1 - i : i;

    assign oneHot[Pos] = bits[Pos] & ~seen[i]; // First set bit wins.
    assign seen[i+1] = seen[i] | bits[Pos];
  end

  // End of the chain is the OR of every bit.
  assign found = seen[NUM_TAGS];

endmodule

//--- src/freeListPkg.sv
package freeListPkg;

  // Tag index. Wide enough for 256 physical registers.
  typedef logic [7:0] tagT;
  typedef logic [31:0] dataT;
  typedef logic [3:0] regAddrT;

  typedef struct packed
  {
    logic valid;
    logic [3:0] needed; // One bit per slot.
  } allocReqT;

  // Slots 0..3 are lowest, second lowest, highest and second highest free tag.
  typedef struct packed
  {
    logic stall;
    logic [3:0] grantValid;
    tagT [3:0] tag;
  } allocRespT;

  typedef struct packed
  {
    logic [1:0] valid;
    tagT [1:0] tag;
  } releaseReqT;

  typedef struct packed
  {
    logic psel;
    logic penable;
    logic pwrite;
    regAddrT paddr;
    dataT pwdata;
  } apbReqT;

  typedef struct packed
  {
    dataT prdata;
    logic pready;
    logic pslverr;
  } apbRespT;

  localparam regAddrT ctrlAddr = 4'h0;
  localparam regAddrT freeCountAddr = 4'h4;
  localparam regAddrT stallCountAddr = 4'h8;
  localparam regAddrT statusAddr = 4'hC; // Write 1 to clear.

endpackage
